// ==== rtl/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// datapath widths
`define SIZE_PC 32
`define SIZE_INSTRUCTION 32

// slots per fetch bundle
`define FETCH_BANDWIDTH 4

// CTI queue sizing, tag width is log2 of depth
`define CTI_QUEUE_DEPTH 16
`define SIZE_CTI_LOG 4

// byte distance between slots in the PISA layout
`define INST_STRIDE 8

`endif

// ==== rtl/fetchPkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetchPkg;

  typedef logic [`SIZE_PC-1:0] pcT;
  typedef logic [`SIZE_INSTRUCTION-1:0] instT;
  typedef logic [`SIZE_CTI_LOG-1:0] ctiTagT;

  // encoding shared with the BTB and predictor update path
  typedef enum logic [1:0] {
    ctReturn = 2'd0,
    ctCall   = 2'd1,
    ctJump   = 2'd2,
    ctCond   = 2'd3
  } ctiTypeE;

  // BTB and predictor view of one slot
  typedef struct packed {
    logic hit;
    pcT   target;
    logic prediction;
  } btbSlotT;

  typedef struct packed {
    instT   instruction;
    pcT     pc;
    pcT     target;
    ctiTagT tag;
    logic   prediction;
  } instPacketT;

  // early redirect toward fetch stage 1
  typedef struct packed {
    logic flagRecover;
    logic flagRtr;
    logic flagCall;
    pcT   target;
    pcT   callPc;
  } recoverT;

  typedef struct packed {
    logic   valid;
    ctiTagT tag;
    pcT     target;
    logic   taken;
  } resolveT;

  typedef struct packed {
    pcT      pc;
    pcT      target;
    ctiTypeE ctiType;
    logic    taken;
  } btbUpdateT;

  typedef struct packed {
    pcT      pc;
    ctiTypeE ctiType;
    pcT      predTarget;
    pcT      resTarget;
    logic    taken;
    logic    resolved;
  } ctiEntryT;

endpackage

`default_nettype wire

// ==== rtl/preDecode.sv ====
`default_nettype none

`include "fetch_macros.svh"

module preDecode (
  input  fetchPkg::instT    instr_i,
  input  fetchPkg::pcT      pc_i,
  input  fetchPkg::pcT      btbTarget_i,
  output logic              isCtrl_o,
  output fetchPkg::ctiTypeE ctiType_o,
  output fetchPkg::pcT      target_o
);

  // control opcodes live in bits 31:24
  localparam logic [7:0] opJump   = 8'h01;
  localparam logic [7:0] opCall   = 8'h02;
  localparam logic [7:0] opReturn = 8'h03;
  localparam logic [7:0] opCond   = 8'h04;

  localparam fetchPkg::pcT stride = fetchPkg::pcT'(`INST_STRIDE);

  logic [7:0]   opcode;
  fetchPkg::pcT offset;
  fetchPkg::pcT fallThrough;
  fetchPkg::pcT directTarget;

  assign opcode = instr_i[31:24];

  // sign-extended displacement counted in instructions
  assign offset = {{(`SIZE_PC-16){instr_i[15]}}, instr_i[15:0]};

  assign fallThrough  = pc_i + stride;
  assign directTarget = fallThrough + offset * stride;

  always_comb begin
    isCtrl_o  = 1'b1;
    ctiType_o = fetchPkg::ctJump;
    target_o  = directTarget;
    case (opcode)
      opJump: begin
        ctiType_o = fetchPkg::ctJump;
      end
      opCall: begin
        ctiType_o = fetchPkg::ctCall;
      end
      opReturn: begin
        // no direct target, trust the BTB until RAS fix-up
        ctiType_o = fetchPkg::ctReturn;
        target_o  = btbTarget_i;
      end
      opCond: begin
        ctiType_o = fetchPkg::ctCond;
      end
      default: begin
        isCtrl_o = 1'b0;
        target_o = fallThrough;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/ctiQueue.sv ====
`default_nettype none

`include "fetch_macros.svh"

module ctiQueue (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        stall_i,
  input  logic                        flush_i,
  input  logic                        fs1Ready_i,
  input  logic [`FETCH_BANDWIDTH-1:0] pushVec_i,
  input  fetchPkg::pcT                slotPc_i     [`FETCH_BANDWIDTH],
  input  fetchPkg::ctiTypeE           slotType_i   [`FETCH_BANDWIDTH],
  input  fetchPkg::pcT                slotTarget_i [`FETCH_BANDWIDTH],
  output fetchPkg::ctiTagT            tag_o        [`FETCH_BANDWIDTH],
  input  fetchPkg::resolveT           resolve_i,
  input  logic                        flagRecoverEx_i,
  input  logic                        commit_i,
  output fetchPkg::btbUpdateT         btbUpdate_o,
  output logic                        updateEn_o,
  output logic                        full_o
);

  fetchPkg::ctiEntryT ctiMem [`CTI_QUEUE_DEPTH];

  fetchPkg::ctiTagT            head;
  fetchPkg::ctiTagT            tail;
  fetchPkg::ctiTagT            headNext;
  fetchPkg::ctiTagT            pushTail;
  logic [`SIZE_CTI_LOG:0]      count;
  logic [`SIZE_CTI_LOG:0]      pushNum;
  logic [`SIZE_CTI_LOG:0]      rollCount;
  logic                        pushEn;
  logic [`FETCH_BANDWIDTH-1:0] pushFire;
  logic                        commitFire;
  fetchPkg::ctiEntryT          headEntry;

  // fewer than one bundle worth of free entries
  assign full_o = count > (`CTI_QUEUE_DEPTH - `FETCH_BANDWIDTH);

  assign pushEn   = fs1Ready_i & ~stall_i & ~full_o & ~flush_i & ~flagRecoverEx_i;
  assign pushFire = pushVec_i & {`FETCH_BANDWIDTH{pushEn}};

  assign commitFire = commit_i & (count != '0);
  assign headEntry  = ctiMem[head];
  assign headNext   = head + fetchPkg::ctiTagT'(commitFire);

  // everything up to and including the mispredicted entry survives
  assign rollCount = {1'b0, fetchPkg::ctiTagT'(resolve_i.tag - head)} + 1'b1;

  // tags handed out in slot order from the tail
  always_comb begin
    pushTail = tail;
    pushNum  = '0;
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      tag_o[k] = pushTail;
      if (pushVec_i[k]) begin
        pushTail = pushTail + 1'b1;
        pushNum  = pushNum + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end else begin
      updateEn_o <= commitFire;
      head       <= headNext;
      if (flush_i) begin
        tail  <= headNext;
        count <= '0;
      end else if (flagRecoverEx_i) begin
        tail  <= resolve_i.tag + 1'b1;
        count <= rollCount - commitFire;
      end else if (pushEn) begin
        tail  <= pushTail;
        count <= count + pushNum - commitFire;
      end else begin
        count <= count - commitFire;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      if (pushFire[k]) begin
        ctiMem[tag_o[k]] <= '{
          pc:         slotPc_i[k],
          ctiType:    slotType_i[k],
          predTarget: slotTarget_i[k],
          resTarget:  slotTarget_i[k],
          taken:      1'b0,
          resolved:   1'b0
        };
      end
    end
    // execute outcome overrides the fetch-time guess
    if (resolve_i.valid) begin
      ctiMem[resolve_i.tag].resTarget <= resolve_i.target;
      ctiMem[resolve_i.tag].taken     <= resolve_i.taken;
      ctiMem[resolve_i.tag].resolved  <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (commitFire) begin
      btbUpdate_o <= '{
        pc:      headEntry.pc,
        target:  headEntry.resTarget,
        ctiType: headEntry.ctiType,
        taken:   headEntry.taken
      };
    end
  end

  // retire only what execute has already resolved
  commitResolved: assert property (
    @(posedge clk) disable iff (reset_i)
    commit_i |-> (count != '0) && headEntry.resolved
  );

  resolveInRange: assert property (
    @(posedge clk) disable iff (reset_i)
    resolve_i.valid |-> ({1'b0, fetchPkg::ctiTagT'(resolve_i.tag - head)} < count)
  );

  countBound: assert property (
    @(posedge clk) disable iff (reset_i)
    count <= `CTI_QUEUE_DEPTH
  );

endmodule

`default_nettype wire

// ==== rtl/fetchStage2.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetchStage2 (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          stall_i,
  input  logic                                          flush_i,
  input  logic                                          fs1Ready_i,
  input  fetchPkg::pcT                                  pc_i,
  input  logic [`FETCH_BANDWIDTH*`SIZE_INSTRUCTION-1:0] instructionBundle_i,
  input  fetchPkg::btbSlotT                             btbSlot_i [`FETCH_BANDWIDTH],
  input  fetchPkg::pcT                                  rasAddr_i,
  input  fetchPkg::resolveT                             resolve_i,
  input  logic                                          flagRecoverEx_i,
  input  logic                                          commit_i,
  output logic [`FETCH_BANDWIDTH-1:0]                   instValid_o,
  output fetchPkg::instPacketT                          instPacket_o [`FETCH_BANDWIDTH],
  output fetchPkg::recoverT                             recover_o,
  output fetchPkg::btbUpdateT                           btbUpdate_o,
  output logic                                          updateEn_o,
  output logic                                          fs2Ready_o,
  output logic                                          ctiQueueFull_o
);

  localparam int slotIdxW = $clog2(`FETCH_BANDWIDTH);

  fetchPkg::instT    slotInstr [`FETCH_BANDWIDTH];
  fetchPkg::pcT      slotPc    [`FETCH_BANDWIDTH];
  fetchPkg::pcT      decTarget [`FETCH_BANDWIDTH];
  fetchPkg::pcT      fixTarget [`FETCH_BANDWIDTH];
  fetchPkg::ctiTypeE ctiType   [`FETCH_BANDWIDTH];
  fetchPkg::ctiTagT  ctiTag    [`FETCH_BANDWIDTH];

  logic [`FETCH_BANDWIDTH-1:0] isCtrl;
  logic [`FETCH_BANDWIDTH-1:0] isCond;
  logic [`FETCH_BANDWIDTH-1:0] takenVec;
  logic [`FETCH_BANDWIDTH-1:0] pushVec;
  logic                        hasEnd;
  logic [slotIdxW-1:0]         endIdx;
  fetchPkg::recoverT           recover;
  logic                        queueFull;

  for (genvar k = 0; k < `FETCH_BANDWIDTH; k++) begin : gSlot
    assign slotInstr[k] = instructionBundle_i[k*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION];
    assign slotPc[k]    = pc_i + fetchPkg::pcT'(k * `INST_STRIDE);

    preDecode preDecode_i (
      .instr_i    (slotInstr[k]),
      .pc_i       (slotPc[k]),
      .btbTarget_i(btbSlot_i[k].target),
      .isCtrl_o   (isCtrl[k]),
      .ctiType_o  (ctiType[k]),
      .target_o   (decTarget[k])
    );

    assign isCond[k] = isCtrl[k] & (ctiType[k] == fetchPkg::ctCond);
    // unconditional CTIs always redirect, branches follow the predictor
    assign takenVec[k] = isCtrl[k] & (~isCond[k] | btbSlot_i[k].prediction);
  end

  // first taken CTI ends the bundle
  always_comb begin
    hasEnd = 1'b0;
    endIdx = slotIdxW'(`FETCH_BANDWIDTH - 1);
    for (int k = `FETCH_BANDWIDTH - 1; k >= 0; k--) begin
      if (takenVec[k]) begin
        hasEnd = 1'b1;
        endIdx = slotIdxW'(k);
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      instValid_o[k] = ~hasEnd | (k <= endIdx);
      // not-taken branches still need a queue slot for resolution
      pushVec[k] = (instValid_o[k] & isCond[k]) | (hasEnd & (k == endIdx));
    end
  end

  // BTB miss on the ending CTI means fetch went the wrong way
  always_comb begin
    fixTarget              = decTarget;
    recover                = '0;
    recover.target         = decTarget[endIdx];
    recover.callPc         = slotPc[endIdx];
    if (hasEnd && !btbSlot_i[endIdx].hit) begin
      recover.flagRecover = 1'b1;
      if (ctiType[endIdx] == fetchPkg::ctReturn) begin
        recover.flagRtr   = 1'b1;
        recover.target    = rasAddr_i;
        fixTarget[endIdx] = rasAddr_i;
      end
      if (ctiType[endIdx] == fetchPkg::ctCall) begin
        recover.flagCall = 1'b1;
      end
    end
  end

  always_comb begin
    recover_o             = recover;
    recover_o.flagRecover = recover.flagRecover & ~stall_i & ~queueFull;
  end

  always_comb begin
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      instPacket_o[k] = '{
        instruction: slotInstr[k],
        pc:          slotPc[k],
        target:      fixTarget[k],
        tag:         ctiTag[k],
        prediction:  btbSlot_i[k].prediction
      };
    end
  end

  ctiQueue ctiQueue_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .stall_i        (stall_i),
    .flush_i        (flush_i),
    .fs1Ready_i     (fs1Ready_i),
    .pushVec_i      (pushVec),
    .slotPc_i       (slotPc),
    .slotType_i     (ctiType),
    .slotTarget_i   (fixTarget),
    .tag_o          (ctiTag),
    .resolve_i      (resolve_i),
    .flagRecoverEx_i(flagRecoverEx_i),
    .commit_i       (commit_i),
    .btbUpdate_o    (btbUpdate_o),
    .updateEn_o     (updateEn_o),
    .full_o         (queueFull)
  );

  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

  // valid slots run without holes up to the first taken CTI
  validPrefix: assert property (
    @(posedge clk) disable iff (reset_i)
    instValid_o[0] && (((instValid_o + 1'b1) & instValid_o) == '0) &&
    ((takenVec & (instValid_o >> 1)) == '0) &&
    ((&instValid_o) || ((takenVec & instValid_o) != '0))
  );

endmodule

`default_nettype wire

// ==== bench/fetchStage2Tb.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetchStage2Tb;

  localparam int recWords = 27;
  localparam int maxRecs  = 16;
  localparam int updWait  = 4;

  logic                                          clk;
  logic                                          reset;
  logic                                          stall;
  logic                                          flush;
  logic                                          fs1Ready;
  fetchPkg::pcT                                  pc;
  logic [`FETCH_BANDWIDTH*`SIZE_INSTRUCTION-1:0] bundle;
  fetchPkg::btbSlotT                             btbSlot [`FETCH_BANDWIDTH];
  fetchPkg::pcT                                  rasAddr;
  fetchPkg::resolveT                             resolve;
  logic                                          recoverEx;
  logic                                          commit;
  logic [`FETCH_BANDWIDTH-1:0]                   instValid;
  fetchPkg::instPacketT                          instPacket [`FETCH_BANDWIDTH];
  fetchPkg::recoverT                             recover;
  fetchPkg::btbUpdateT                           btbUpdate;
  logic                                          updateEn;
  logic                                          fs2Ready;
  logic                                          queueFull;

  logic [31:0] stim [recWords*maxRecs];
  int          mismatches;
  int          failures;

  fetchStage2 fetchStage2_i (
    .clk                (clk),
    .reset_i            (reset),
    .stall_i            (stall),
    .flush_i            (flush),
    .fs1Ready_i         (fs1Ready),
    .pc_i               (pc),
    .instructionBundle_i(bundle),
    .btbSlot_i          (btbSlot),
    .rasAddr_i          (rasAddr),
    .resolve_i          (resolve),
    .flagRecoverEx_i    (recoverEx),
    .commit_i           (commit),
    .instValid_o        (instValid),
    .instPacket_o       (instPacket),
    .recover_o          (recover),
    .btbUpdate_o        (btbUpdate),
    .updateEn_o         (updateEn),
    .fs2Ready_o         (fs2Ready),
    .ctiQueueFull_o     (queueFull)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic checkValid(input string name, input logic [`FETCH_BANDWIDTH-1:0] exp,
                            input logic [`FETCH_BANDWIDTH-1:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s valid expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic checkPacket(input string name, input fetchPkg::instPacketT exp,
                             input fetchPkg::instPacketT act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s packet expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkRecover(input string name, input fetchPkg::recoverT exp,
                              input fetchPkg::recoverT act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s recover expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkUpdate(input string name, input fetchPkg::btbUpdateT exp,
                             input fetchPkg::btbUpdateT act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s update expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic driveIdle();
    stall     = 1'b0;
    flush     = 1'b0;
    fs1Ready  = 1'b0;
    pc        = '0;
    bundle    = '0;
    rasAddr   = '0;
    resolve   = '0;
    recoverEx = 1'b0;
    commit    = 1'b0;
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      btbSlot[k] = '0;
    end
  endtask

  task automatic driveRecord(input int base);
    logic [31:0] ctl;
    ctl            = stim[base];
    fs1Ready       = ctl[0];
    stall          = ctl[1];
    resolve.valid  = ctl[2];
    recoverEx      = ctl[3];
    commit         = ctl[4];
    flush          = ctl[5];
    pc             = stim[base+1];
    rasAddr        = stim[base+9];
    resolve.tag    = fetchPkg::ctiTagT'(stim[base+10]);
    resolve.target = stim[base+11];
    resolve.taken  = stim[base+12][0];
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      bundle[k*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION] = stim[base+2+k];
      btbSlot[k].hit        = stim[base+6][k];
      btbSlot[k].target     = stim[base+8];
      btbSlot[k].prediction = stim[base+7][k];
    end
  endtask

  task automatic checkBundle(input int base, input string name);
    fetchPkg::instPacketT expPkt;
    fetchPkg::recoverT    expRec;
    checkValid(name, stim[base+17][`FETCH_BANDWIDTH-1:0], instValid);
    for (int k = 0; k < `FETCH_BANDWIDTH; k++) begin
      // slot PCs step by the fixed instruction stride
      expPkt.instruction = stim[base+2+k];
      expPkt.pc          = fetchPkg::pcT'(stim[base+1] + k * `INST_STRIDE);
      expPkt.target      = stim[base+19+k];
      expPkt.tag         = fetchPkg::ctiTagT'(stim[base+18] >> (4 * k));
      expPkt.prediction  = stim[base+7][k];
      checkPacket($sformatf("%s slot %0d", name, k), expPkt, instPacket[k]);
    end
    expRec.flagRecover = stim[base+23][0];
    expRec.flagRtr     = stim[base+23][1];
    expRec.flagCall    = stim[base+23][2];
    expRec.target      = stim[base+24];
    expRec.callPc      = stim[base+25];
    checkRecover(name, expRec, recover);
  endtask

  task automatic waitUpdate(input string name, input fetchPkg::btbUpdateT exp);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < updWait) begin
      @(negedge clk);
      driveIdle();
      seen = updateEn;
      n++;
    end
    if (seen) begin
      checkUpdate(name, exp, btbUpdate);
    end else begin
      failures++;
      $display("%s: update never arrived within %0d cycles", name, updWait);
    end
  endtask

  task automatic runStep(input int idx);
    int                  base;
    string               name;
    logic [31:0]         ctl;
    fetchPkg::btbUpdateT expUpd;
    base = idx * recWords;
    name = $sformatf("step %0d", idx + 1);
    ctl  = stim[base];
    @(negedge clk);
    driveRecord(base);
    // outputs settle well before the next rising edge
    #25;
    checkBit({name, " updateEn"}, 1'b0, updateEn);
    checkBit({name, " full"}, stim[base+26][0], queueFull);
    checkBit({name, " fs2Ready"}, stim[base+26][1], fs2Ready);
    if (ctl[0]) begin
      checkBundle(base, name);
    end
    @(posedge clk);
    if (ctl[6]) begin
      expUpd.pc      = stim[base+13];
      expUpd.target  = stim[base+14];
      expUpd.ctiType = fetchPkg::ctiTypeE'(stim[base+15][1:0]);
      expUpd.taken   = stim[base+16][0];
      waitUpdate(name, expUpd);
    end
  endtask

  initial begin
    int   steps;
    logic done;
    mismatches = 0;
    failures   = 0;
    steps      = 0;
    done       = 1'b0;
    driveIdle();
    reset = 1'b1;
    $readmemh("bench/fetchStage2_input.txt", stim);
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #25;
    checkBit("reset updateEn", 1'b0, updateEn);
    checkBit("reset full", 1'b0, queueFull);
    // bit 31 of the control word marks the last record
    for (int r = 0; r < maxRecs && !done; r++) begin
      if (stim[r*recWords][31] !== 1'b0) begin
        done = 1'b1;
      end else begin
        runStep(r);
        steps++;
      end
    end
    if (steps == 0) begin
      failures++;
      $display("no test steps could be read from the stimulus file");
    end
    $display("%0d steps run, %0d mismatches, %0d other failures", steps, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetchStage2.f ====
+incdir+rtl
rtl/fetchPkg.sv
rtl/preDecode.sv
rtl/ctiQueue.sv
rtl/fetchStage2.sv
bench/fetchStage2Tb.sv

// ==== bench/fetchStage2_input.txt ====
// line 1: ctl pc inst0..inst3 btbHit btbPred btbTarget rasAddr resTag resTarget resTaken
// line 2: updPc updTarget updType updTaken expValid expTags expTarget0..3 recFlags recTarget callPc flags
// ctl bits: 0 bundle, 1 stall, 2 resolve, 3 recoverEx, 4 commit, 5 flush, 6 expect update, 31 end
// expTags holds slot k in nibble k, recFlags is {call, rtr, recover}, flags is {fs2Ready, full}
1 1000 10000000 20000001 00000002 05000003 0 0 0 0 0 0 0
0 0 0 0 f 0000 1008 1010 1018 1020 0 1020 1018 2
1 2000 04000004 00000000 01000010 0400fffe 4 0 0 0 0 0 0
0 0 0 0 7 2110 2028 2010 2098 2010 0 2098 2010 2
5 3000 00000000 03000000 00000000 00000000 0 0 5550 4444 0 2028 1
0 0 0 0 3 3322 3008 4444 3018 3020 3 4444 3008 2
55 6000 02000002 00000000 00000000 00000000 0 0 0 0 1 2098 1
2000 2028 3 1 1 4443 6018 6010 6018 6020 5 6018 6000 2
54 0 0 0 0 0 0 0 0 0 2 4444 1
2010 2098 2 1 0 0 0 0 0 0 0 0 0 0
// fill the queue with not-taken branches
5 7000 04000000 04000000 04000000 0400fffc 0 0 0 0 3 6018 1
0 0 0 0 f 7654 7008 7010 7018 7000 0 7000 7018 2
1 8000 04000000 04000000 04000000 04000000 0 0 0 0 0 0 0
0 0 0 0 f ba98 8008 8010 8018 8020 0 8020 8018 2
1 9000 04000000 04000000 04000000 04000000 0 0 0 0 0 0 0
0 0 0 0 f fedc 9008 9010 9018 9020 0 9020 9018 2
51 a000 03000000 00000000 00000000 00000000 0 0 0 bbb0 0 0 0
3008 4444 0 1 1 1110 bbb0 a010 a018 a020 2 bbb0 a000 1
50 0 0 0 0 0 0 0 0 0 0 0 0
6000 6018 1 1 0 0 0 0 0 0 0 0 0 1
// rollback, then flush
d c000 00000000 00000000 00000000 00000000 0 0 0 0 5 1234 1
0 0 0 0 f 0000 c008 c010 c018 c020 0 c020 c018 2
21 d000 04000001 00000000 00000000 00000000 0 0 0 0 0 0 0
0 0 0 0 f 7776 d010 d010 d018 d020 0 d020 d018 2
1 e000 01000000 00000000 00000000 00000000 1 0 0 0 0 0 0
0 0 0 0 1 5554 e008 e010 e018 e020 0 e008 e000 2
80000000
